/* sources.f */
design/drive_pkg.sv
design/drive_mount.sv
design/drive_mode_reset.sv
design/head_stepper.sv
design/track_loader.sv
design/drive_mech.sv
test/drive_checker.sv
test/drive_tb.sv

/* test/drive_tb.sv */
`timescale 1ns/1ps

module drive_tb;
	import drive_pkg::*;

	// request kind as {rd, wr}
	typedef enum logic [1:0] {
		REQ_NO = 2'b00,
		REQ_WR = 2'b01,
		REQ_RD = 2'b10
	} req_kind_t;

	// one row, actions first, then expected results
	typedef struct packed {
		logic [6:0] steps;
		logic       step_out;
		logic       side;
		logic       wr;
		logic       idle;
		logic [1:0] mount;
		logic       mode;
		mount_t     exp_mount;
		logic [1:0] exp_n;
		req_kind_t  first_kind;
		logic [7:0] first_trk;
		req_kind_t  last_kind;
		logic [7:0] last_trk;
	} row_t;

	// mount 1 is a read-only image, mount 2 an empty one
	// n of 3 means one or more requests, count not fixed
	row_t rows [16] = '{
		// steps out  side  wr    idle  mnt   mode  mount   n     first         last
		'{7'd0,   1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 3'b001, 2'd1, REQ_NO, 8'd0, REQ_RD, 8'd36},
		'{7'd1,   1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 3'b001, 2'd1, REQ_NO, 8'd0, REQ_RD, 8'd37},
		'{7'd1,   1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 3'b001, 2'd1, REQ_NO, 8'd0, REQ_RD, 8'd36},
		'{7'd1,   1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 3'b001, 2'd1, REQ_NO, 8'd0, REQ_RD, 8'd35},
		'{7'd60,  1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 3'b001, 2'd3, REQ_NO, 8'd0, REQ_RD, 8'd84},
		'{7'd100, 1'b1, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 3'b001, 2'd3, REQ_NO, 8'd0, REQ_RD, 8'd0},
		'{7'd1,   1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 3'b001, 2'd1, REQ_NO, 8'd0, REQ_RD, 8'd1},
		'{7'd0,   1'b0, 1'b1, 1'b0, 1'b0, 2'd0, 1'b0, 3'b001, 2'd1, REQ_NO, 8'd0, REQ_RD, 8'd85},
		'{7'd0,   1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 3'b001, 2'd1, REQ_NO, 8'd0, REQ_RD, 8'd1},
		'{7'd1,   1'b0, 1'b0, 1'b1, 1'b0, 2'd0, 1'b0, 3'b001, 2'd2, REQ_WR, 8'd1, REQ_RD, 8'd2},
		'{7'd0,   1'b0, 1'b0, 1'b1, 1'b1, 2'd0, 1'b0, 3'b001, 2'd1, REQ_NO, 8'd0, REQ_WR, 8'd2},
		'{7'd0,   1'b0, 1'b0, 1'b0, 1'b0, 2'd1, 1'b0, 3'b111, 2'd0, REQ_NO, 8'd0, REQ_NO, 8'd0},
		'{7'd0,   1'b0, 1'b0, 1'b0, 1'b0, 2'd2, 1'b0, 3'b000, 2'd0, REQ_NO, 8'd0, REQ_NO, 8'd0},
		'{7'd0,   1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b1, 3'b000, 2'd1, REQ_NO, 8'd0, REQ_RD, 8'd36},
		'{7'd1,   1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 3'b000, 2'd1, REQ_NO, 8'd0, REQ_RD, 8'd37},
		'{7'd100, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0, 1'b0, 3'b000, 2'd3, REQ_NO, 8'd0, REQ_RD, 8'd168}
	};

	logic        clk;
	logic        reset;
	logic [1:0]  drv_mode;
	logic        ph2;
	logic        ce;
	logic        img_mounted;
	logic        img_readonly;
	logic [31:0] img_size;
	logic [1:0]  stp;
	logic        mtr;
	logic        side;
	logic        wgate;
	logic        hclk;
	logic        act;
	logic        sd_ack;
	mount_t      mount;
	sd_req_t     sd_req;
	logic        led;
	integer      seed = 90;
	int          errors = 0;
	int          rows_failed = 0;
	// every request the card model has seen, in order
	req_kind_t   req_kind_q [$];
	logic [31:0] req_lba_q [$];

	drive_mech dut (
		.clk            (clk),
		.reset          (reset),
		.drv_mode_i     (drv_mode),
		.ph2_i          (ph2),
		.ce_i           (ce),
		.img_mounted_i  (img_mounted),
		.img_readonly_i (img_readonly),
		.img_size_i     (img_size),
		.stp_i          (stp),
		.mtr_i          (mtr),
		.side_i         (side),
		.wgate_i        (wgate),
		.hclk_i         (hclk),
		.act_i          (act),
		.sd_ack_i       (sd_ack),
		.mount_o        (mount),
		.sd_req_o       (sd_req),
		.led_o          (led)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// bound from the table length
	initial begin
		repeat ($size(rows) * 400) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", $size(rows) * 400);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	// ------------------------------------------------------------
	// SD card model
	// ------------------------------------------------------------
	initial begin
		int wait_cycles;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk);
			if (sd_req.rd || sd_req.wr) begin
				req_kind_q.push_back(req_kind_t'({sd_req.rd, sd_req.wr}));
				req_lba_q.push_back(sd_req.lba);
				check_val("sd_req_o.blk_cnt", 32'(sd_req.blk_cnt), TRACK_BLOCKS - 1);
				// led stays lit for the whole transfer
				check_val("led_o", 32'(led), 32'd1);
				// card latency 1 to 8 cycles
				wait_cycles = 1 + ($random(seed) & 7);
				repeat (wait_cycles) @(negedge clk);
				sd_ack = 1'b1;
				// ack spans one track of blocks
				repeat (TRACK_BLOCKS) @(negedge clk);
				sd_ack = 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// row stimulus and checks
	// ------------------------------------------------------------
	task automatic apply_row(input row_t r);
		act = 1'b1;
		side = r.side;
		if (r.mount != 2'd0) begin
			@(negedge clk);
			img_readonly = (r.mount == 2'd1);
			img_size = (r.mount == 2'd1) ? 32'd174848 : 32'd0;
			img_mounted = 1'b1;
			repeat (2) @(negedge clk);
			img_mounted = 1'b0;
		end
		if (r.mode) begin
			@(negedge clk);
			drv_mode = drv_mode + 2'd1;
		end
		// one cycle of write data dirties the track
		if (r.wr) begin
			@(negedge clk);
			wgate = 1'b1;
			hclk = 1'b1;
			@(negedge clk);
			wgate = 1'b0;
			hclk = 1'b0;
		end
		// one phase per cycle
		for (int s = 0; s < r.steps; s++) begin
			@(negedge clk);
			stp = r.step_out ? stp - 2'd1 : stp + 2'd1;
		end
		if (r.idle) begin
			@(negedge clk);
			act = 1'b0;
		end
	endtask

	task automatic wait_idle(input int row_idx);
		int cycles;
		cycles = 0;
		// let the change ripple through to the loader
		repeat (4) @(negedge clk);
		while (dut.u_loader.busy_o && cycles < 600) begin
			@(negedge clk);
			cycles++;
		end
		if (dut.u_loader.busy_o) begin
			$display("row %0d: loader still busy after %0d cycles", row_idx, cycles);
			errors++;
		end
	endtask

	task automatic check_row(input row_t r, input int base);
		int n;
		int last;
		n = req_kind_q.size() - base;
		last = req_kind_q.size() - 1;
		check_val("mount_o", 32'(mount), 32'(r.exp_mount));
		// with the loader quiet the led follows drive activity
		check_val("led_o", 32'(led), 32'(act));
		if (r.exp_n != 2'd3) begin
			check_val("request count", n, 32'(r.exp_n));
		end else if (n == 0) begin
			$display("no SD request seen where one was expected");
			errors++;
		end
		// save goes out before the read
		if (r.exp_n == 2'd2 && n >= 2) begin
			check_val("sd_req_o.rd/wr", 32'(req_kind_q[base]), 32'(r.first_kind));
			check_val("sd_req_o.lba", req_lba_q[base], 32'(r.first_trk) * TRACK_BLOCKS);
		end
		if (r.exp_n != 2'd0 && n > 0) begin
			check_val("sd_req_o.rd/wr", 32'(req_kind_q[last]), 32'(r.last_kind));
			check_val("sd_req_o.lba", req_lba_q[last], 32'(r.last_trk) * TRACK_BLOCKS);
		end
	endtask

	initial begin
		int err_before;
		int base;
		reset = 1'b1;
		drv_mode = 2'd0;
		// one ph2 strobe per clock
		ph2 = 1'b1;
		ce = 1'b1;
		img_mounted = 1'b0;
		img_readonly = 1'b0;
		img_size = 32'd0;
		stp = 2'd0;
		mtr = 1'b1;
		side = 1'b0;
		wgate = 1'b0;
		hclk = 1'b0;
		act = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < $size(rows); i++) begin
			err_before = errors;
			base = req_kind_q.size();
			apply_row(rows[i]);
			wait_idle(i);
			check_row(rows[i], base);
			if (errors == err_before) begin
				$display("row %0d: ok", i);
			end else begin
				$display("row %0d: mismatch", i);
				rows_failed++;
			end
		end
		errors = errors + dut.u_loader.u_checker.fail_cnt;
		$display("rows %0d, failed %0d, errors %0d", $size(rows), rows_failed, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* test/drive_checker.sv */
`timescale 1ns/1ps

module drive_checker (
	input logic               clk,
	input logic               drive_reset_i,
	input drive_pkg::head_t   head_i,
	input logic               sd_ack_i,
	input drive_pkg::sd_req_t sd_req_i
);
	import drive_pkg::*;

	logic req_on;
	// failed assertions, read back at the end of the run
	int   fail_cnt = 0;

	assign req_on = sd_req_i.rd || sd_req_i.wr;

	// ------------------------------------------------------------
	// SD handshake
	// ------------------------------------------------------------

	// one transfer direction at a time
	rd_wr_excl: assert property (@(posedge clk) disable iff (drive_reset_i)
		!(sd_req_i.rd && sd_req_i.wr))
		else begin
			$error("rd and wr asserted together");
			fail_cnt++;
		end

	// address frozen from strobe until the transfer is over
	lba_hold: assert property (@(posedge clk) disable iff (drive_reset_i)
		req_on |=> $stable(sd_req_i.lba))
		else begin
			$error("lba changed while a request was pending");
			fail_cnt++;
		end

	// strobe stays up until the card answers
	req_wait: assert property (@(posedge clk) disable iff (drive_reset_i)
		req_on && !sd_ack_i |=> req_on)
		else begin
			$error("request dropped before ack");
			fail_cnt++;
		end

	// head never leaves the combined two-side range
	track_range: assert property (@(posedge clk) disable iff (drive_reset_i)
		head_i.track <= HEAD_TRACK_W'(TRACK_MAX) + SIDE_OFFSET)
		else begin
			$error("head track out of range");
			fail_cnt++;
		end

endmodule

// watch the loader from the inside
bind track_loader drive_checker u_checker (
	.clk           (clk),
	.drive_reset_i (drive_reset_i),
	.head_i        (head_i),
	.sd_ack_i      (sd_ack_i),
	.sd_req_i      (sd_req_o)
);

/* design/drive_mech.sv */
`timescale 1ns/1ps

module drive_mech (
	input  logic               clk,
	input  logic               reset,
	input  logic [1:0]         drv_mode_i,
	input  logic               ph2_i,
	input  logic               ce_i,
	input  logic               img_mounted_i,
	input  logic               img_readonly_i,
	input  logic [31:0]        img_size_i,
	input  logic [1:0]         stp_i,
	input  logic               mtr_i,
	input  logic               side_i,
	input  logic               wgate_i,
	input  logic               hclk_i,
	input  logic               act_i,
	input  logic               sd_ack_i,
	output drive_pkg::mount_t  mount_o,
	output drive_pkg::sd_req_t sd_req_o,
	output logic               led_o
);
	import drive_pkg::*;

	logic  drive_reset;
	head_t head;
	logic  busy;

	// ------------------------------------------------------------
	// media and reset
	// ------------------------------------------------------------

	// mount tracking runs on system reset only
	drive_mount u_mount (
		.clk            (clk),
		.reset          (reset),
		.img_mounted_i  (img_mounted_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.ce_i           (ce_i),
		.mount_o        (mount_o)
	);

	drive_mode_reset u_mode_reset (
		.clk           (clk),
		.reset         (reset),
		.drv_mode_i    (drv_mode_i),
		.ph2_i         (ph2_i),
		.drive_reset_o (drive_reset)
	);

	// ------------------------------------------------------------
	// head and track storage
	// ------------------------------------------------------------
	head_stepper u_stepper (
		.clk           (clk),
		.drive_reset_i (drive_reset),
		.img_mounted_i (img_mounted_i),
		.stp_i         (stp_i),
		.mtr_i         (mtr_i),
		.side_i        (side_i),
		.wgate_i       (wgate_i),
		.hclk_i        (hclk_i),
		.act_i         (act_i),
		.head_o        (head)
	);

	track_loader u_loader (
		.clk           (clk),
		.drive_reset_i (drive_reset),
		.head_i        (head),
		.sd_ack_i      (sd_ack_i),
		.sd_req_o      (sd_req_o),
		.busy_o        (busy)
	);

	// lit while the drive works or a track is in transfer
	assign led_o = act_i || busy;

endmodule

/* design/track_loader.sv */
`timescale 1ns/1ps

module track_loader (
	input  logic               clk,
	input  logic               drive_reset_i,
	input  drive_pkg::head_t   head_i,
	input  logic               sd_ack_i,
	output drive_pkg::sd_req_t sd_req_o,
	output logic               busy_o
);
	import drive_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQ,
		ST_DONE
	} state_t;

	state_t                  state_q;
	sd_req_t                 req_q;
	logic [HEAD_TRACK_W-1:0] loaded_q;
	logic [HEAD_TRACK_W-1:0] target_q;
	logic                    last_tgl_q;
	logic                    tgl_q;
	logic                    first_q;
	logic                    is_wr_q;
	logic                    save_pend;
	logic                    load_pend;

	// first block of a track in the image
	function automatic logic [LBA_W-1:0] track_lba(input logic [HEAD_TRACK_W-1:0] trk);
		return LBA_W'(trk) * LBA_W'(TRACK_BLOCKS);
	endfunction

	// ------------------------------------------------------------
	// pending work
	// ------------------------------------------------------------

	// stepper toggled since the last finished write
	assign save_pend = head_i.save_tgl != last_tgl_q;
	// head sits on a track other than the buffered one
	assign load_pend = first_q || (head_i.track != loaded_q);

	// ------------------------------------------------------------
	// request FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (drive_reset_i) begin
			state_q    <= ST_IDLE;
			req_q.rd   <= 1'b0;
			req_q.wr   <= 1'b0;
			first_q    <= 1'b1;
			// no save is owed across a drive reset
			last_tgl_q <= head_i.save_tgl;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (save_pend) begin
						// old track goes back first
						req_q.lba     <= track_lba(loaded_q);
						req_q.blk_cnt <= TRACK_BLK_CNT;
						req_q.wr      <= 1'b1;
						is_wr_q       <= 1'b1;
						tgl_q         <= head_i.save_tgl;
						state_q       <= ST_REQ;
					end else if (load_pend) begin
						req_q.lba     <= track_lba(head_i.track);
						req_q.blk_cnt <= TRACK_BLK_CNT;
						req_q.rd      <= 1'b1;
						is_wr_q       <= 1'b0;
						target_q      <= head_i.track;
						state_q       <= ST_REQ;
					end
				end
				ST_REQ: begin
					// card took it, drop the strobe
					if (sd_ack_i) begin
						req_q.rd <= 1'b0;
						req_q.wr <= 1'b0;
						state_q  <= ST_DONE;
					end
				end
				ST_DONE: begin
					// transfer over once ack falls
					if (!sd_ack_i) begin
						if (is_wr_q) begin
							last_tgl_q <= tgl_q;
						end else begin
							loaded_q <= target_q;
							first_q  <= 1'b0;
						end
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	assign sd_req_o = req_q;
	// busy covers queued work as well as the transfer itself
	assign busy_o = (state_q != ST_IDLE) || save_pend || load_pend;

endmodule

/* design/head_stepper.sv */
`timescale 1ns/1ps

module head_stepper (
	input  logic             clk,
	input  logic             drive_reset_i,
	input  logic             img_mounted_i,
	input  logic [1:0]       stp_i,
	input  logic             mtr_i,
	input  logic             side_i,
	input  logic             wgate_i,
	input  logic             hclk_i,
	input  logic             act_i,
	output drive_pkg::head_t head_o
);
	import drive_pkg::*;

	logic [1:0]              stp_q;
	logic [1:0]              move_q;
	logic                    side_q;
	logic [TRACK_W-1:0]      track_num_q;
	logic [HEAD_TRACK_W-1:0] track_q;
	logic                    modified_q;
	logic                    save_tgl_q;
	logic                    step_in;
	logic                    step_out;
	logic                    side_chg;
	logic                    save_now;
	logic [HEAD_TRACK_W-1:0] side_add;

	// ------------------------------------------------------------
	// stepper decode
	// ------------------------------------------------------------

	// phase diff 1 moves inward, 3 moves outward
	assign step_in  = mtr_i && (move_q == 2'd1);
	assign step_out = mtr_i && (move_q == 2'd3);
	assign side_chg = side_i != side_q;

	// head leaves a dirty track, or drive goes quiet on one
	assign save_now = modified_q && ((mtr_i && move_q[0]) || side_chg || !act_i);

	assign side_add = side_i ? SIDE_OFFSET : '0;

	always_ff @(posedge clk) begin
		// phase history always follows the motor lines
		stp_q  <= stp_i;
		move_q <= stp_i - stp_q;
		side_q <= side_i;

		// combined track lags the half-track by one cycle
		track_q <= HEAD_TRACK_W'(track_num_q) + side_add;

		// write activity dirties the track
		if (wgate_i && hclk_i)
			modified_q <= 1'b1;
		// fresh image, nothing to save
		if (img_mounted_i)
			modified_q <= 1'b0;

		if (drive_reset_i) begin
			move_q      <= '0;
			side_q      <= 1'b0;
			track_num_q <= TRACK_START;
			track_q     <= HEAD_TRACK_W'(TRACK_START);
			modified_q  <= 1'b0;
			save_tgl_q  <= 1'b0;
		end else begin
			// clamp at both ends of the range
			if (step_in && track_num_q < TRACK_MAX)
				track_num_q <= track_num_q + 1'b1;
			else if (step_out && track_num_q != '0)
				track_num_q <= track_num_q - 1'b1;

			// one toggle per save request
			if (save_now) begin
				save_tgl_q <= !save_tgl_q;
				modified_q <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------
	assign head_o.track    = track_q;
	assign head_o.save_tgl = save_tgl_q;

endmodule

/* design/drive_mode_reset.sv */
`timescale 1ns/1ps

module drive_mode_reset (
	input  logic       clk,
	input  logic       reset,
	input  logic [1:0] drv_mode_i,
	input  logic       ph2_i,
	output logic       drive_reset_o
);
	import drive_pkg::*;

	logic [1:0]             last_mode_q;
	logic                   hold_q;
	logic [MODE_HOLD_W-1:0] hold_cnt_q;

	// ------------------------------------------------------------
	// mode change detect, one compare per ph2 strobe
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			// take the current mode so release is not a change
			last_mode_q <= drv_mode_i;
			hold_q      <= 1'b0;
			hold_cnt_q  <= '0;
		end else if (ph2_i) begin
			last_mode_q <= drv_mode_i;
			if (drv_mode_i != last_mode_q) begin
				// new mode, restart the hold window
				hold_cnt_q <= MODE_HOLD;
				hold_q     <= 1'b1;
			end else if (hold_q) begin
				hold_cnt_q <= hold_cnt_q - 1'b1;
				// last strobe of the window
				if (hold_cnt_q == MODE_HOLD_W'(1))
					hold_q <= 1'b0;
			end
		end
	end

	// system reset passes straight through
	assign drive_reset_o = reset || hold_q;

endmodule

/* design/drive_mount.sv */
`timescale 1ns/1ps

module drive_mount (
	input  logic              clk,
	input  logic              reset,
	input  logic              img_mounted_i,
	input  logic              img_readonly_i,
	input  logic [31:0]       img_size_i,
	input  logic              ce_i,
	output drive_pkg::mount_t mount_o
);
	import drive_pkg::*;

	logic                     mounted_q;
	logic                     mount_edge_q;
	logic                     readonly_q;
	logic                     present_q;
	logic [CHG_TIMEOUT_W-1:0] chg_cnt_q;

	// ------------------------------------------------------------
	// mount edge, registered
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			mounted_q    <= 1'b0;
			mount_edge_q <= 1'b0;
		end else begin
			mounted_q    <= img_mounted_i;
			mount_edge_q <= img_mounted_i && !mounted_q;
		end
	end

	// latch media flags, restart disk change countdown
	always_ff @(posedge clk) begin
		if (reset) begin
			readonly_q <= 1'b0;
			present_q  <= 1'b0;
			chg_cnt_q  <= '0;
		end else begin
			// countdown runs on the drive clock enable
			if (ce_i && chg_cnt_q != '0)
				chg_cnt_q <= chg_cnt_q - 1'b1;
			// a new mount overrides the countdown
			if (mount_edge_q) begin
				readonly_q <= img_readonly_i;
				present_q  <= |img_size_i;
				chg_cnt_q  <= '1;
			end
		end
	end

	// protect sensor flickers while the disk is being swapped
	assign mount_o.disk_present = present_q;
	assign mount_o.readonly     = readonly_q;
	assign mount_o.wps_n        = !readonly_q ^ chg_cnt_q[CHG_FLICKER_BIT];

endmodule

/* design/drive_pkg.sv */
package drive_pkg;

	// ------------------------------------------------------------
	// track geometry
	// ------------------------------------------------------------

	// half-track number of one side, 0 .. TRACK_MAX
	localparam int TRACK_W = 7;
	// combined track number, side offset included
	localparam int HEAD_TRACK_W = 8;

	// highest half-track the head may reach
	localparam logic [TRACK_W-1:0] TRACK_MAX = 7'd84;
	// head position right after a drive reset
	localparam logic [TRACK_W-1:0] TRACK_START = 7'd36;
	// side 1 tracks sit above the side 0 range
	localparam logic [HEAD_TRACK_W-1:0] SIDE_OFFSET = 8'd84;

	// ------------------------------------------------------------
	// SD card transfer
	// ------------------------------------------------------------

	localparam int LBA_W = 32;
	localparam int BLK_CNT_W = 6;

	// one track image spans this many SD blocks
	localparam int TRACK_BLOCKS = 8;
	// block count field is "blocks minus one"
	localparam logic [BLK_CNT_W-1:0] TRACK_BLK_CNT = BLK_CNT_W'(TRACK_BLOCKS - 1);

	// ------------------------------------------------------------
	// drive mode change and disk change
	// ------------------------------------------------------------

	// ph2 strobes the drive stays in reset after a mode change
	localparam int MODE_HOLD_W = 8;
	localparam logic [MODE_HOLD_W-1:0] MODE_HOLD = 8'd255;

	// disk change countdown, one bit of it flickers write protect
	localparam int CHG_TIMEOUT_W = 24;
	localparam int CHG_FLICKER_BIT = 22;

	// ------------------------------------------------------------
	// shared structs
	// ------------------------------------------------------------

	// media state seen by the drive
	typedef struct packed {
		logic disk_present;
		logic readonly;
		logic wps_n;
	} mount_t;

	// head position plus save request toggle
	typedef struct packed {
		logic [HEAD_TRACK_W-1:0] track;
		logic                    save_tgl;
	} head_t;

	// request side of the SD handshake
	typedef struct packed {
		logic [LBA_W-1:0]     lba;
		logic [BLK_CNT_W-1:0] blk_cnt;
		logic                 rd;
		logic                 wr;
	} sd_req_t;

endpackage
